/* common/fe_params.svh */
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// Sizing of the fetch front end

// Width of every instruction address
`define FE_XLEN 32

// First address fetched out of reset
`define FE_RESET_PC 32'h0000_1000

// Direct-mapped BTB geometry
`define FE_BTB_ENTRIES 16

// Index bits taken from PC[5:2]
// Must stay log2 of FE_BTB_ENTRIES
`define FE_BTB_IDX_W 4

`endif

/* common/fe_types_pkg.sv */
`include "fe_params.svh"

// Datapath types shared by the fetch front end
package fe_types_pkg;

  // Instruction address
  typedef logic [`FE_XLEN-1:0] addr_t;

  // BTB index comes from the word address bits just above the byte offset
  typedef logic [`FE_BTB_IDX_W-1:0] btb_idx_t;

  // Tag is everything above the index
  // 26 bits for a 32-bit address and 16 entries
  typedef logic [`FE_XLEN-`FE_BTB_IDX_W-3:0] btb_tag_t;

  // Where the next PC comes from
  typedef enum logic [1:0] {
    PC_SRC_SEQ      = 2'd0,
    PC_SRC_PRED     = 2'd1,
    PC_SRC_REDIRECT = 2'd2
  } pc_src_t;

  // Request handed to instruction memory
  // predicted marks an address that came from a BTB hit
  typedef struct packed {
    addr_t pc;
    logic  predicted;
  } fetch_req_t;

endpackage

/* common/fe_ctrl_pkg.sv */
// Control messages from the back end into fetch
package fe_ctrl_pkg;

  // Redirect after a resolved branch or mispredict
  // Also flushes the held fetch request
  typedef struct packed {
    logic                valid;
    fe_types_pkg::addr_t target;
  } redirect_t;

  // BTB training write
  // pc selects the entry, target is what a later hit returns
  typedef struct packed {
    logic                valid;
    fe_types_pkg::addr_t pc;
    fe_types_pkg::addr_t target;
  } btb_update_t;

endpackage

/* btb/btb.sv */
`timescale 1ns/1ps
`include "fe_params.svh"

// Direct-mapped branch target buffer
// Lookup is combinational on the current PC
// Update writes on the clock edge, visible to lookups the cycle after
module btb (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fe_types_pkg::addr_t      lookup_pc,
  input  fe_ctrl_pkg::btb_update_t update,
  output logic                     pred_hit,
  output fe_types_pkg::addr_t      pred_target
);

  import fe_types_pkg::*;

  // Bit positions of index and tag in a PC
  localparam int unsigned IDX_LO = 2;
  localparam int unsigned TAG_LO = IDX_LO + `FE_BTB_IDX_W;

  // Per-entry state
  logic [`FE_BTB_ENTRIES-1:0] valid_q;
  btb_tag_t                   tag_q    [`FE_BTB_ENTRIES];
  addr_t                      target_q [`FE_BTB_ENTRIES];

  // Split fields of the lookup and update addresses
  btb_idx_t lookup_idx;
  btb_tag_t lookup_tag;
  btb_idx_t update_idx;
  btb_tag_t update_tag;

  assign lookup_idx = lookup_pc[TAG_LO-1:IDX_LO];
  assign lookup_tag = lookup_pc[`FE_XLEN-1:TAG_LO];
  assign update_idx = update.pc[TAG_LO-1:IDX_LO];
  assign update_tag = update.pc[`FE_XLEN-1:TAG_LO];

  // Hit needs a live entry whose tag matches
  // An aliasing PC with the same index misses here
  always_comb begin
    pred_hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    pred_target = target_q[lookup_idx];
  end

  // Valid bits are control state and clear on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (update.valid) begin
      valid_q[update_idx] <= 1'b1;
    end
  end

  // Tag and target arrays
  // An update simply overwrites whatever sat in the slot
  always_ff @(posedge clk) begin
    if (update.valid) begin
      tag_q[update_idx]    <= update_tag;
      target_q[update_idx] <= update.target;
    end
  end

endmodule

/* logic/pc_select.sv */
`timescale 1ns/1ps

// Fixed-priority choice of the next PC source
// Redirect beats prediction, prediction beats sequential
module pc_select (
  input  fe_ctrl_pkg::redirect_t redirect,
  input  logic                   pred_hit,
  output fe_types_pkg::pc_src_t  pc_src
);

  import fe_types_pkg::*;

  // Single place where the priority rule lives
  always_comb begin
    if (redirect.valid) begin
      // Back end correction always wins
      pc_src = PC_SRC_REDIRECT;
    end else if (pred_hit) begin
      // Follow the BTB for a learned PC
      pc_src = PC_SRC_PRED;
    end else begin
      // Fall through to pc+4
      pc_src = PC_SRC_SEQ;
    end
  end

endmodule

/* logic/pc_stage.sv */
`timescale 1ns/1ps
`include "fe_params.svh"

// Program counter register with its three-way next-PC mux
// Moves only when the issue register takes the current PC or a flush occurs
module pc_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fe_types_pkg::pc_src_t pc_src,
  input  fe_types_pkg::addr_t   redirect_target,
  input  fe_types_pkg::addr_t   pred_target,
  input  logic                  advance,
  output fe_types_pkg::addr_t   pc,
  output logic                  pred_taken
);

  import fe_types_pkg::*;

  addr_t pc_next;

  // Next PC selection
  always_comb begin
    case (pc_src)
      PC_SRC_REDIRECT: pc_next = redirect_target;
      PC_SRC_PRED:     pc_next = pred_target;
      default:         pc_next = pc + addr_t'(4);
    endcase
  end

  // PC register and its predicted flag
  // The flag travels with the address it describes, so a predicted
  // target reaches the issue register marked as predicted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc         <= `FE_RESET_PC;
      pred_taken <= 1'b0;
    end else if (advance) begin
      pc         <= pc_next;
      pred_taken <= (pc_src == PC_SRC_PRED);
    end
  end

endmodule

/* logic/fetch_issue.sv */
`timescale 1ns/1ps

// One-entry fetch request register
// Ready/valid toward instruction memory, transfer when both are high
module fetch_issue (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fe_types_pkg::addr_t      pc,
  input  logic                     pred_taken,
  input  logic                     flush,
  input  logic                     fetch_ready,
  output logic                     advance,
  output logic                     fetch_valid,
  output fe_types_pkg::fetch_req_t fetch_req
);

  // Register takes a new PC this edge
  logic load;

  // PC may move on when the slot is free, is being drained, or is flushed
  assign advance = flush || !fetch_valid || fetch_ready;

  // Flush discards instead of loading
  assign load = advance && !flush;

  // Valid bit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_valid <= 1'b0;
    end else if (flush) begin
      // Drop the stale request so the redirect target is next out
      fetch_valid <= 1'b0;
    end else if (load) begin
      fetch_valid <= 1'b1;
    end
  end

  // Request payload
  // Holds steady under back-pressure since load stays low
  always_ff @(posedge clk) begin
    if (load) begin
      fetch_req.pc        <= pc;
      fetch_req.predicted <= pred_taken;
    end
  end

endmodule

/* logic/fetch_frontend.sv */
`timescale 1ns/1ps

// Instruction fetch front end
// Source selection, PC stage with BTB, and the fetch issue register
module fetch_frontend (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fe_ctrl_pkg::redirect_t   redirect,
  input  fe_ctrl_pkg::btb_update_t btb_update,
  input  logic                     fetch_ready,
  output logic                     fetch_valid,
  output fe_types_pkg::fetch_req_t fetch_req
);

  import fe_types_pkg::*;

  // Internal nets between the blocks
  addr_t   pc;
  addr_t   pred_target;
  logic    pred_hit;
  logic    pred_taken;
  logic    advance;
  pc_src_t pc_src;

  // BTB looks up the PC currently held
  btb u_btb (
    .clk         (clk),
    .rst_n       (rst_n),
    .lookup_pc   (pc),
    .update      (btb_update),
    .pred_hit    (pred_hit),
    .pred_target (pred_target)
  );

  pc_select u_pc_select (
    .redirect (redirect),
    .pred_hit (pred_hit),
    .pc_src   (pc_src)
  );

  pc_stage u_pc_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_src          (pc_src),
    .redirect_target (redirect.target),
    .pred_target     (pred_target),
    .advance         (advance),
    .pc              (pc),
    .pred_taken      (pred_taken)
  );

  // Redirect valid doubles as the flush of the held request
  fetch_issue u_fetch_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc          (pc),
    .pred_taken  (pred_taken),
    .flush       (redirect.valid),
    .fetch_ready (fetch_ready),
    .advance     (advance),
    .fetch_valid (fetch_valid),
    .fetch_req   (fetch_req)
  );

endmodule

/* verification/tb_fetch_frontend.sv */
`timescale 1ns/1ps
`include "fe_params.svh"

// Testbench for the instruction fetch front end
module tb_fetch_frontend;

  import fe_types_pkg::*;
  import fe_ctrl_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int RANDOM_CYCLES = 300;

  // One stimulus line plus the outputs expected after its edge
  typedef struct packed {
    logic        ready;
    redirect_t   redirect;
    btb_update_t update;
    logic        exp_valid;
    fetch_req_t  exp_req;
  } stim_row_t;

  logic        clk = 1'b0;
  logic        rst_n;
  redirect_t   redirect;
  btb_update_t btb_update;
  logic        fetch_ready;
  logic        fetch_valid;
  fetch_req_t  fetch_req;

  stim_row_t rows[$];
  logic      stim_loaded = 1'b0;
  int        watchdog_ns;

  // Cycle model of PC register, BTB and issue register
  addr_t                      m_pc;
  logic                       m_pc_pred;
  logic                       m_valid;
  fetch_req_t                 m_req;
  logic [`FE_BTB_ENTRIES-1:0] m_btb_valid;
  btb_tag_t                   m_btb_tag    [`FE_BTB_ENTRIES];
  addr_t                      m_btb_target [`FE_BTB_ENTRIES];

  fetch_frontend u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .btb_update  (btb_update),
    .fetch_ready (fetch_ready),
    .fetch_valid (fetch_valid),
    .fetch_req   (fetch_req)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string reason);
    $display("*** FAILED ***");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s expected %0b, got %0b", $time, name, expected, actual);
      abort_run("fetch_valid mismatch");
    end
  endtask

  task automatic check_req(input string name, input fetch_req_t expected,
                           input fetch_req_t actual);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s expected pc %h pred %0b, got pc %h pred %0b",
               $time, name, expected.pc, expected.predicted, actual.pc, actual.predicted);
      abort_run("fetch_req mismatch");
    end
  endtask

  // Xorshift32 step
  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reads the stimulus file and skips the '#' column notes
  task automatic load_stimulus();
    int          fd;
    int          n;
    int          cnt;
    string       line;
    logic [31:0] f_ready;
    logic [31:0] f_rv;
    logic [31:0] f_rt;
    logic [31:0] f_uv;
    logic [31:0] f_upc;
    logic [31:0] f_ut;
    logic [31:0] f_ev;
    logic [31:0] f_epc;
    logic [31:0] f_ep;
    stim_row_t   row;
    fd = $fopen("verification/fetch_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("could not open verification/fetch_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                      f_ready, f_rv, f_rt, f_uv, f_upc, f_ut, f_ev, f_epc, f_ep);
        if (cnt == 9) begin
          row.ready             = f_ready[0];
          row.redirect.valid    = f_rv[0];
          row.redirect.target   = f_rt;
          row.update.valid      = f_uv[0];
          row.update.pc         = f_upc;
          row.update.target     = f_ut;
          row.exp_valid         = f_ev[0];
          row.exp_req.pc        = f_epc;
          row.exp_req.predicted = f_ep[0];
          rows.push_back(row);
        end else if (cnt > 0) begin
          abort_run("malformed line in stimulus file");
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic reset_model();
    m_pc        = `FE_RESET_PC;
    m_pc_pred   = 1'b0;
    m_valid     = 1'b0;
    m_req       = '0;
    m_btb_valid = '0;
  endtask

  // One rising edge of the model
  task automatic step_model(input stim_row_t row);
    btb_idx_t idx;
    logic     hit;
    logic     adv;
    addr_t    nxt;
    logic     nxt_pred;
    // Lookup uses PC bits 5:2 as index and 31:6 as tag
    idx = m_pc[5:2];
    hit = m_btb_valid[idx] && (m_btb_tag[idx] == m_pc[31:6]);
    adv = row.redirect.valid || !m_valid || row.ready;
    // Redirect first, then prediction, then pc+4
    if (row.redirect.valid) begin
      nxt      = row.redirect.target;
      nxt_pred = 1'b0;
    end else if (hit) begin
      nxt      = m_btb_target[idx];
      nxt_pred = 1'b1;
    end else begin
      nxt      = m_pc + 32'd4;
      nxt_pred = 1'b0;
    end
    // Issue register drops its request on a flush and loads nothing
    if (row.redirect.valid) begin
      m_valid = 1'b0;
    end else if (adv) begin
      m_valid         = 1'b1;
      m_req.pc        = m_pc;
      m_req.predicted = m_pc_pred;
    end
    if (adv) begin
      m_pc      = nxt;
      m_pc_pred = nxt_pred;
    end
    // BTB write lands after this edge's lookup
    if (row.update.valid) begin
      m_btb_valid[row.update.pc[5:2]]  = 1'b1;
      m_btb_tag[row.update.pc[5:2]]    = row.update.pc[31:6];
      m_btb_target[row.update.pc[5:2]] = row.update.target;
    end
  endtask

  task automatic drive_inputs(input stim_row_t row);
    fetch_ready = row.ready;
    redirect    = row.redirect;
    btb_update  = row.update;
  endtask

  // Drive on the falling edge, step the model on the rising edge
  // and compare on the next falling edge
  task automatic run_cycle(input stim_row_t row, input logic file_expect);
    drive_inputs(row);
    @(posedge clk);
    step_model(row);
    @(negedge clk);
    check_valid("fetch_valid", m_valid, fetch_valid);
    if (m_valid) begin
      check_req("fetch_req", m_req, fetch_req);
    end
    if (file_expect) begin
      check_valid("fetch_valid vs file", row.exp_valid, fetch_valid);
      if (row.exp_valid) begin
        check_req("fetch_req vs file", row.exp_req, fetch_req);
      end
    end
  endtask

  // Run length follows the stimulus size
  initial begin
    wait (stim_loaded);
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    abort_run("watchdog timeout");
  end

  initial begin
    logic [31:0] rng;
    stim_row_t   row;
    rst_n       = 1'b0;
    fetch_ready = 1'b0;
    redirect    = '0;
    btb_update  = '0;
    reset_model();
    load_stimulus();
    if (rows.size() == 0) begin
      abort_run("stimulus file holds no rows");
    end
    watchdog_ns = (rows.size() + RANDOM_CYCLES + 20) * CLK_PERIOD;
    stim_loaded = 1'b1;
    $display("Stimulus rows: %0d, random cycles: %0d", rows.size(), RANDOM_CYCLES);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Nothing issued out of reset
    check_valid("fetch_valid after reset", 1'b0, fetch_valid);
    foreach (rows[i]) begin
      run_cycle(rows[i], 1'b1);
    end
    // Random back-pressure with about three in four cycles ready
    rng = 32'h7ea3ead1;
    repeat (RANDOM_CYCLES) begin
      rng       = next_rand(rng);
      row       = '0;
      row.ready = (rng[1:0] != 2'b00);
      run_cycle(row, 1'b0);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* verification/fetch_stimulus.txt */
# ready rd_valid rd_target upd_valid upd_pc upd_target exp_valid exp_pc exp_pred
# One line per cycle in hex, exp_* are fetch_valid and fetch_req after that cycle's edge
1 0 00000000 0 00000000 00000000 1 00001000 0
1 0 00000000 0 00000000 00000000 1 00001004 0
0 0 00000000 0 00000000 00000000 1 00001004 0
0 0 00000000 0 00000000 00000000 1 00001004 0
1 0 00000000 0 00000000 00000000 1 00001008 0
0 0 00000000 0 00000000 00000000 1 00001008 0
0 1 00002000 0 00000000 00000000 0 00000000 0
0 0 00000000 0 00000000 00000000 1 00002000 0
1 0 00000000 0 00000000 00000000 1 00002004 0
1 1 00003000 0 00000000 00000000 0 00000000 0
1 0 00000000 1 00003008 00004000 1 00003000 0
1 0 00000000 0 00000000 00000000 1 00003004 0
1 0 00000000 0 00000000 00000000 1 00003008 0
1 0 00000000 0 00000000 00000000 1 00004000 1
1 0 00000000 1 00005008 00006000 1 00004004 0
1 1 00003000 0 00000000 00000000 0 00000000 0
1 0 00000000 0 00000000 00000000 1 00003000 0
1 0 00000000 0 00000000 00000000 1 00003004 0
1 0 00000000 0 00000000 00000000 1 00003008 0
1 0 00000000 0 00000000 00000000 1 0000300c 0
1 1 00005008 0 00000000 00000000 0 00000000 0
1 1 00007000 0 00000000 00000000 0 00000000 0
1 0 00000000 0 00000000 00000000 1 00007000 0
1 0 00000000 0 00000000 00000000 1 00007004 0
1 1 00005008 0 00000000 00000000 0 00000000 0
1 0 00000000 0 00000000 00000000 1 00005008 0
1 0 00000000 0 00000000 00000000 1 00006000 1
0 0 00000000 0 00000000 00000000 1 00006000 1
1 0 00000000 0 00000000 00000000 1 00006004 0

/* compile.f */
+incdir+common
common/fe_types_pkg.sv
common/fe_ctrl_pkg.sv
btb/btb.sv
logic/pc_select.sv
logic/pc_stage.sv
logic/fetch_issue.sv
logic/fetch_frontend.sv
verification/tb_fetch_frontend.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_fetch_frontend \
  -f compile.f --Mdir obj_dir -o tb_fetch_frontend > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_fetch_frontend > sim.log 2>&1
cat sim.log
grep -q -x '\*\*\* PASSED \*\*\*' sim.log && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }
